/* hw/io_ring.sv */
/* Pad ring top. Pin to pad_o is combinational; pins reach core_in_o after
   2 clk edges, the USB data bit after 3. Pins are split into pad_i/pad_o. */

module io_ring (
  // Clock and reset
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  // Package pins
  input  logic                  [io_ring_pkg::n_ios-1:0] pad_i,
  output io_ring_pkg::pad_drv_t  [io_ring_pkg::n_ios-1:0] pad_o,
  output io_ring_pkg::usb_pu_t                           usb_pu_o,
  // Core side
  input  io_ring_pkg::core_out_t                         core_i,
  input  io_ring_pkg::pad_attr_t [io_ring_pkg::n_ios-1:0] attr_i,
  output logic                  [io_ring_pkg::n_ios-1:0] core_in_o,
  // JTAG tap
  output io_ring_pkg::jtag_t                             jtag_o,
  input  logic                                           jtag_tdo_i,
  // USB
  input  logic                                           usb_rx_en_i
);

  import io_ring_pkg::*;

  core_out_t        core_muxed; // After JTAG overlay
  logic [n_ios-1:0] rx_pad;     // Pad receivers, after invert
  logic [n_ios-1:0] rx_merged;  // With USB data slot filled
  logic [n_ios-1:0] rx_core;    // After overlay, before sync
  logic             usb_d;      // Differential receiver output

  ////////////////////
  // Pad cells
  ////////////////////

  pad_drive_array u_pad_drive_array (
    .drv_i  ( core_muxed ),
    .attr_i ( attr_i     ),
    .pad_i  ( pad_i      ),
    .pad_o  ( pad_o      ),
    .rx_o   ( rx_pad     )
  );

  ////////////////////
  // USB receiver
  ////////////////////

  usb_diff_rx u_usb_diff_rx (
    .clk_i    ( clk_i            ),
    .arst_n_i ( arst_n_i         ),
    .en_i     ( usb_rx_en_i      ),
    .p_i      ( pad_i[usb_p_idx] ), // Raw pins, invert does not apply
    .n_i      ( pad_i[usb_n_idx] ),
    .d_o      ( usb_d            )
  );

  // USB D has no pin of its own, the receiver fills its slot
  always_comb begin
    rx_merged            = rx_pad;
    rx_merged[usb_d_idx] = usb_d;
  end

  ////////////////////
  // JTAG overlay
  ////////////////////

  jtag_overlay_mux u_jtag_overlay_mux (
    .core_i     ( core_i     ),
    .rx_o       ( rx_core    ),
    .core_o     ( core_muxed ),
    .rx_i       ( rx_merged  ),
    .jtag_o     ( jtag_o     ),
    .jtag_tdo_i ( jtag_tdo_i ),
    .usb_pu_o   ( usb_pu_o   )
  );

  ////////////////////
  // Input sync
  ////////////////////

  pad_in_sync #(
    .width ( n_ios )
  ) u_pad_in_sync (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .d_i      ( rx_core   ),
    .q_o      ( core_in_o )
  );

endmodule : io_ring

/* hw/io_ring_pkg.sv */
/* Pad counts, the pad-variant table and the JTAG pin map are fixed here.
   MIO pads sit in the low indices of the combined vector, DIO pads above. */

package io_ring_pkg;

  ////////////////////
  // Pad counts
  ////////////////////

  localparam int n_mio_pads = 12;                      // Muxed pads
  localparam int n_dio_pads = 6;                       // Dedicated pads
  localparam int n_ios      = n_mio_pads + n_dio_pads; // Combined vector width

  // Encoding follows the pad library variant field
  typedef enum logic [1:0] {
    pad_bidir      = 2'd0,
    pad_input_only = 2'd1,
    pad_tolerant   = 2'd2,
    pad_open_drain = 2'd3
  } pad_variant_e;

  localparam pad_variant_e pad_variant_tbl [n_ios] = '{
    pad_bidir,       // MIO 0
    pad_bidir,       // MIO 1
    pad_bidir,       // MIO 2
    pad_bidir,       // MIO 3
    pad_open_drain,  // MIO 4
    pad_open_drain,  // MIO 5
    pad_bidir,       // MIO 6  TMS when overlaid
    pad_bidir,       // MIO 7  TDI
    pad_bidir,       // MIO 8  TRST
    pad_bidir,       // MIO 9  TCK
    pad_open_drain,  // MIO 10 TDO
    pad_open_drain,  // MIO 11 JTAG enable strap
    pad_tolerant,    // DIO 0  USB P
    pad_tolerant,    // DIO 1  USB N
    pad_bidir,       // DIO 2  USB D, internal slot
    pad_bidir,       // DIO 3  SPI data
    pad_input_only,  // DIO 4  SPI CS_L
    pad_input_only   // DIO 5  SPI CLK
  };

  ////////////////////
  // Pin map
  ////////////////////

  localparam int jtag_en_idx = 11;
  localparam int tck_idx     = 9;
  localparam int tms_idx     = 6;
  localparam int trst_idx    = 8;
  localparam int tdi_idx     = 7;
  localparam int tdo_idx     = 10;

  localparam int usb_p_idx   = n_mio_pads + 0;
  localparam int usb_n_idx   = n_mio_pads + 1;
  localparam int usb_d_idx   = n_mio_pads + 2; // Also DP pull-up out slot
  localparam int spi_csb_idx = n_mio_pads + 4;

  // Pads taken over while JTAG is enabled
  localparam logic [n_ios-1:0] jtag_steal_mask =
    (n_ios'(1) << jtag_en_idx) | (n_ios'(1) << tck_idx) | (n_ios'(1) << tms_idx) |
    (n_ios'(1) << trst_idx) | (n_ios'(1) << tdi_idx) | (n_ios'(1) << tdo_idx);

  // CS_L is active low, so its idle value is 1
  localparam logic [n_ios-1:0] jtag_tie_off = n_ios'(1) << spi_csb_idx;

  ////////////////////
  // Structs
  ////////////////////

  typedef struct packed {
    logic invert;  // Applies to both directions
    logic keeper;  // Spare, no effect in this ring
  } pad_attr_t;

  typedef struct packed {
    logic en;   // Pin is driven
    logic val;  // Driven level, 0 when released
  } pad_drv_t;

  typedef struct packed {
    logic [n_ios-1:0] out;
    logic [n_ios-1:0] oe;
  } core_out_t;

  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic tdi;
  } jtag_t;

  typedef struct packed {
    logic dp_pu_en;
    logic dn_pu_en;
  } usb_pu_t;

endpackage : io_ring_pkg

/* hw/jtag_overlay_mux.sv */
/* JTAG overlay is selected by the jtag_en pad as seen after invert.
   Stolen pads are forced in both directions; USB pull-ups are broken out
   from the DIO 2 and DIO 3 out bits regardless of the overlay. */

module jtag_overlay_mux (
  // Core side
  input  io_ring_pkg::core_out_t          core_i,
  output logic [io_ring_pkg::n_ios-1:0]   rx_o,
  // Pad side
  output io_ring_pkg::core_out_t          core_o,
  input  logic [io_ring_pkg::n_ios-1:0]   rx_i,
  // JTAG tap
  output io_ring_pkg::jtag_t              jtag_o,
  input  logic                            jtag_tdo_i,
  // USB breakouts
  output io_ring_pkg::usb_pu_t            usb_pu_o
);

  import io_ring_pkg::*;

  logic jtag_en; // Overlay active

  assign jtag_en = rx_i[jtag_en_idx]; // Strap pin, active high

  ////////////////////
  // Outward path
  ////////////////////

  always_comb begin
    core_o = core_i;                                // Pass through by default
    if (jtag_en) begin
      core_o.oe           = core_i.oe & ~jtag_steal_mask; // Release stolen pads
      core_o.out[tdo_idx] = jtag_tdo_i;             // TDO takes its pad
      core_o.oe[tdo_idx]  = 1'b1;
    end
  end

  ////////////////////
  // Inward path
  ////////////////////

  // Stolen slots read the tie-off so the core sees idle values
  // on the pads it lost
  assign rx_o = jtag_en ? ((rx_i & ~jtag_steal_mask) | (jtag_tie_off & jtag_steal_mask))
                        : rx_i;

  always_comb begin
    jtag_o = '0;                      // Tap held in reset when off
    if (jtag_en) begin
      jtag_o.tck    = rx_i[tck_idx];
      jtag_o.tms    = rx_i[tms_idx];
      jtag_o.trst_n = rx_i[trst_idx]; // Pin is already active low
      jtag_o.tdi    = rx_i[tdi_idx];
    end
  end

  ////////////////////
  // USB pull-ups
  ////////////////////

  // DIO 3 doubles as SPI data, the pull-up just follows its out bit
  assign usb_pu_o.dp_pu_en = core_i.out[usb_d_idx];
  assign usb_pu_o.dn_pu_en = core_i.out[usb_d_idx + 1];

endmodule : jtag_overlay_mux

/* hw/pad_drive_array.sv */
/* Purely combinational pad cells. Drive style comes from pad_variant_tbl,
   the invert attribute flips both the driven and the received level. */

module pad_drive_array (
  input  io_ring_pkg::core_out_t                       drv_i,
  input  io_ring_pkg::pad_attr_t [io_ring_pkg::n_ios-1:0] attr_i,
  input  logic                  [io_ring_pkg::n_ios-1:0] pad_i,
  output io_ring_pkg::pad_drv_t  [io_ring_pkg::n_ios-1:0] pad_o,
  output logic                  [io_ring_pkg::n_ios-1:0] rx_o
);

  import io_ring_pkg::*;

  logic [n_ios-1:0] inv_mask; // Invert bits gathered into one word
  logic [n_ios-1:0] eff_lvl;  // Level after invert, core to pin

  ////////////////////
  // Attribute decode
  ////////////////////

  always_comb begin
    for (int i = 0; i < n_ios; i++) begin
      inv_mask[i] = attr_i[i].invert; // Keeper bit is not used here
    end
  end

  assign eff_lvl = drv_i.out ^ inv_mask;

  ////////////////////
  // Output drivers
  ////////////////////

  // Released pads always report val 0, so the pin model sees a clean
  // en/val pair and never a stale level
  always_comb begin
    for (int i = 0; i < n_ios; i++) begin
      pad_o[i] = '0;                                  // Default released
      case (pad_variant_tbl[i])
        pad_bidir, pad_tolerant: begin
          pad_o[i].en  = drv_i.oe[i];                 // Push-pull
          pad_o[i].val = drv_i.oe[i] & eff_lvl[i];
        end
        pad_open_drain: begin
          pad_o[i].en  = drv_i.oe[i] & ~eff_lvl[i];   // Pull low only
          pad_o[i].val = 1'b0;                        // External pull-up gives the 1
        end
        default: begin
          pad_o[i] = '0;                              // Input only, never driven
        end
      endcase
    end
  end

  ////////////////////
  // Receivers
  ////////////////////

  // Every pad has an input buffer, driven pads read back their own level
  assign rx_o = pad_i ^ inv_mask;

endmodule : pad_drive_array

/* hw/pad_in_sync.sv */
/* Two-flop synchronizer, both stages reset to zero.
   Each bit is synchronized on its own, no bus coherence. */

module pad_in_sync #(
  parameter int width = 1
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic [width-1:0] d_i,
  output logic [width-1:0] q_o
);

  logic [width-1:0] meta_q; // First stage, may go metastable
  logic [width-1:0] sync_q; // Second stage, safe to use

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= d_i;
      sync_q <= meta_q;
    end
  end

  assign q_o = sync_q;

endmodule : pad_in_sync

/* hw/usb_diff_rx.sv */
/* Registered model of the differential USB receiver. Output is 0 while
   disabled; SE0 and SE1 hold the last differential value. */

module usb_diff_rx (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic en_i,  // Receiver enable from core
  input  logic p_i,   // Raw D+ pin
  input  logic n_i,   // Raw D- pin
  output logic d_o    // Differential data
);

  logic d_q;
  logic d_d;

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    d_d = d_q;                      // Hold by default
    if (!en_i) begin
      d_d = 1'b0;                   // Disabled reads as 0
    end else begin
      case ({p_i, n_i})
        2'b10:   d_d = 1'b1;        // J state
        2'b01:   d_d = 1'b0;        // K state
        default: d_d = d_q;         // SE0 or SE1
      endcase
    end
  end

  ////////////////////
  // Register
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_q <= 1'b0;
    end else begin
      d_q <= d_d;
    end
  end

  assign d_o = d_q;

endmodule : usb_diff_rx

/* run_sim.sh */
#!/bin/sh
# Build the io_ring testbench with Verilator, run it and check the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing -f sources.f --top-module io_ring_tb -o io_ring_sim \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/io_ring_sim > sim.log 2>&1
cat sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1

/* sources.f */
+incdir+include
hw/io_ring_pkg.sv
hw/pad_drive_array.sv
hw/jtag_overlay_mux.sv
hw/usb_diff_rx.sv
hw/pad_in_sync.sv
hw/io_ring.sv
testbench/io_ring_tb.sv

/* include/io_ring_tb_ref.svh */
/* Reference model of io_ring for the testbench, include inside a module.
   en_pin is the raw jtag_en pin; invert on that pad is applied here. */

`ifndef IO_RING_TB_REF_SVH
`define IO_RING_TB_REF_SVH

// Expected pad_o and usb_pu_o, same cycle as the inputs
function automatic void ref_pad_drive(
  input  io_ring_pkg::core_out_t                          core,
  input  io_ring_pkg::pad_attr_t [io_ring_pkg::n_ios-1:0] attr,
  input  logic                                            tdo,
  input  logic                                            en_pin,
  output io_ring_pkg::pad_drv_t  [io_ring_pkg::n_ios-1:0] pad,
  output io_ring_pkg::usb_pu_t                            pu
);
  logic jtag_en;
  logic oe;
  logic lvl;
  jtag_en     = en_pin ^ attr[io_ring_pkg::jtag_en_idx].invert;
  pu.dp_pu_en = core.out[io_ring_pkg::n_mio_pads + 2];  // DIO 2
  pu.dn_pu_en = core.out[io_ring_pkg::n_mio_pads + 3];  // DIO 3
  for (int i = 0; i < io_ring_pkg::n_ios; i++) begin
    oe  = core.oe[i];
    lvl = core.out[i];
    if (jtag_en && io_ring_pkg::jtag_steal_mask[i]) begin
      oe  = (i == io_ring_pkg::tdo_idx);          // Only TDO drives
      lvl = (i == io_ring_pkg::tdo_idx) ? tdo : lvl;
    end
    lvl    = lvl ^ attr[i].invert;
    pad[i] = '0;
    case (io_ring_pkg::pad_variant_tbl[i])
      io_ring_pkg::pad_bidir, io_ring_pkg::pad_tolerant: begin
        pad[i].en  = oe;
        pad[i].val = oe & lvl;
      end
      io_ring_pkg::pad_open_drain: pad[i].en = oe & ~lvl;
      default:                     pad[i]    = '0;
    endcase
  end
endfunction

// Expected pre-sync core input vector and jtag_o
function automatic void ref_core_in(
  input  logic                   [io_ring_pkg::n_ios-1:0] pad,
  input  io_ring_pkg::pad_attr_t [io_ring_pkg::n_ios-1:0] attr,
  input  logic                                            usb_q,
  output logic                   [io_ring_pkg::n_ios-1:0] core_in,
  output io_ring_pkg::jtag_t                              jtag
);
  logic [io_ring_pkg::n_ios-1:0] rx;
  for (int i = 0; i < io_ring_pkg::n_ios; i++) begin
    rx[i] = pad[i] ^ attr[i].invert;
  end
  rx[io_ring_pkg::usb_d_idx] = usb_q;             // Modeled receiver register
  core_in = rx;
  jtag    = '0;
  if (rx[io_ring_pkg::jtag_en_idx]) begin
    jtag.tck    = rx[io_ring_pkg::tck_idx];
    jtag.tms    = rx[io_ring_pkg::tms_idx];
    jtag.trst_n = rx[io_ring_pkg::trst_idx];
    jtag.tdi    = rx[io_ring_pkg::tdi_idx];
    for (int i = 0; i < io_ring_pkg::n_ios; i++) begin
      if (io_ring_pkg::jtag_steal_mask[i]) begin
        core_in[i] = io_ring_pkg::jtag_tie_off[i]; // Stolen slot reads its tie-off
      end
    end
  end
endfunction

// Next value of the USB receiver register
function automatic logic ref_usb_step(input logic q, input logic en, input logic p,
                                      input logic n);
  if (!en) return 1'b0;
  if (p != n) return p;                           // J or K
  return q;                                       // SE0 or SE1 hold
endfunction

`endif

/* testbench/io_ring_tb.sv */
/* Random testbench for io_ring. Inputs change just after each rising edge,
   outputs are compared at the falling edge; the first error stops the run. */

module io_ring_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import io_ring_pkg::*;

  `include "io_ring_tb_ref.svh"

  localparam int n_idle  = 4;   // USB receiver off, JTAG off
  localparam int n_drive = 60;  // Drive and input path
  localparam int n_jtag  = 40;  // Overlay active
  localparam int n_usb   = 60;  // Receiver on
  localparam int n_total = n_idle + n_drive + n_jtag + n_usb;

  logic                   clk_i;
  logic                   arst_n_i;
  logic      [n_ios-1:0]  pad_i;
  pad_drv_t  [n_ios-1:0]  pad_o;
  usb_pu_t                usb_pu_o;
  core_out_t              core_i;
  pad_attr_t [n_ios-1:0]  attr_i;
  logic      [n_ios-1:0]  core_in_o;
  jtag_t                  jtag_o;
  logic                   jtag_tdo_i;
  logic                   usb_rx_en_i;

  io_ring uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;  // 40 ns period
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic fail_check(input string what, input logic [63:0] got, input logic [63:0] exp);
    $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
    $display("TEST FAILED");
    $fatal(1, "Mismatch on %s", what);
  endtask

  // One cycle of random inputs, jtag_en pin held to the requested mode
  task automatic drive_cycle(input logic jtag_on, input logic usb_on);
    core_out_t             core_v;
    pad_attr_t [n_ios-1:0] attr_v;
    logic      [n_ios-1:0] pad_v;
    core_v.out = n_ios'($urandom());
    core_v.oe  = n_ios'($urandom());
    pad_v      = n_ios'($urandom());
    for (int i = 0; i < n_ios; i++) begin
      attr_v[i].invert = 1'($urandom());
      attr_v[i].keeper = 1'($urandom());
      if (jtag_on && jtag_steal_mask[i]) begin
        attr_v[i].invert = 1'b0;  // No invert on JTAG pads
      end
    end
    pad_v[jtag_en_idx] = jtag_on ? 1'b1 : attr_v[jtag_en_idx].invert; // Effective level
    @(posedge clk_i);
    core_i      <= core_v;
    attr_i      <= attr_v;
    pad_i       <= pad_v;
    jtag_tdo_i  <= 1'($urandom());
    usb_rx_en_i <= usb_on;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    void'($urandom(32'hbc9d0ced));
    arst_n_i    = 1'b0;
    pad_i       = '1;                                    // Pins busy during reset
    core_i      = '0;
    attr_i      = '0;
    jtag_tdo_i  = 1'b0;
    usb_rx_en_i = 1'b0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;                                    // Release after 2 cycles
    repeat (n_idle)  drive_cycle(1'b0, 1'b0);
    repeat (n_drive) drive_cycle(1'b0, 1'b0);
    repeat (n_jtag)  drive_cycle(1'b1, 1'b0);
    repeat (n_usb)   drive_cycle(1'b0, 1'b1);
    repeat (3) @(posedge clk_i);                         // Drain the sync pipeline
    $display("Checked %0d cycles", n_total);
    $display("TEST PASSED");
    $finish;
  end

  ////////////////////
  // Compare
  ////////////////////

  initial begin : compare
    pad_drv_t [n_ios-1:0] exp_pad;
    usb_pu_t              exp_pu;
    logic     [n_ios-1:0] exp_pre;
    jtag_t                exp_jtag;
    logic     [n_ios-1:0] hist [2];  // Pre-sync vectors, 1 and 2 cycles old
    logic                 usb_q;     // Modeled receiver register
    int                   cycle;
    hist[0] = '0;
    hist[1] = '0;
    usb_q   = 1'b0;
    cycle   = 0;
    @(posedge arst_n_i);
    forever begin
      @(negedge clk_i);
      ref_pad_drive(core_i, attr_i, jtag_tdo_i, pad_i[jtag_en_idx], exp_pad, exp_pu);
      ref_core_in(pad_i, attr_i, usb_q, exp_pre, exp_jtag);
      assert (pad_o == exp_pad) else fail_check("pad_o", 64'(pad_o), 64'(exp_pad));
      assert (usb_pu_o == exp_pu) else fail_check("usb_pu_o", 64'(usb_pu_o), 64'(exp_pu));
      assert (jtag_o == exp_jtag) else fail_check("jtag_o", 64'(jtag_o), 64'(exp_jtag));
      if (cycle < 2) begin
        assert (core_in_o == '0) else fail_check("core_in_o after reset", 64'(core_in_o), 0);
      end
      assert (core_in_o == hist[1]) else fail_check("core_in_o", 64'(core_in_o), 64'(hist[1]));
      hist[1] = hist[0];
      hist[0] = exp_pre;
      usb_q   = ref_usb_step(usb_q, usb_rx_en_i, pad_i[usb_p_idx], pad_i[usb_n_idx]);
      cycle++;
    end
  end

  initial begin : watchdog
    #((n_total + 20) * 40);
    $display("Timeout: the run did not finish in the expected time");
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule : io_ring_tb
